/* build.f */
+incdir+verification
verilog/fe_pred_pkg.sv
verilog/fe_addr_pkg.sv
verilog/direction_predictor.sv
verilog/target_buffer.sv
verilog/next_ip_select.sv
verilog/fetch_frontend.sv
verification/fetch_frontend_tb.sv

/* verification/fe_ref_model.svh */
// reference model of the fetch front end: counter tables, target buffer and fetch registers
// included inside the testbench module, after the package imports
`ifndef FE_REF_MODEL_SVH
`define FE_REF_MODEL_SVH

localparam int    M_DIR_IDX_W = 8;
localparam int    M_BTB_IDX_W = 6;
localparam addr_t M_RESET_IP = 'h1000;
localparam int    M_TAG_LSB = 4 + M_BTB_IDX_W;  // tag is everything above the index

ctr_t   m_tbl_a [1 << M_DIR_IDX_W];
ctr_t   m_tbl_b [1 << M_DIR_IDX_W];
logic   m_btb_valid [1 << M_BTB_IDX_W];
addr_t  m_btb_src [1 << M_BTB_IDX_W];
addr_t  m_btb_target [1 << M_BTB_IDX_W];
addr_t  m_ip;
ghist_t m_ghist;
logic   m_valid;

function automatic int btb_slot(addr_t ip);
  return int'(ip[4 +: M_BTB_IDX_W]);
endfunction

function automatic logic model_btb_hit(addr_t ip);
  int s;
  s = btb_slot(ip);
  return m_btb_valid[s] && ((m_btb_src[s] >> M_TAG_LSB) == (ip >> M_TAG_LSB));
endfunction

// sum of both counters, taken from 4 up
function automatic logic model_dir_taken(addr_t ip, ghist_t gh);
  int ia;
  int ib;
  ia = int'(ip[4 +: M_DIR_IDX_W]);
  ib = ia ^ int'(gh[M_DIR_IDX_W-1:0]);
  return (int'(m_tbl_a[ia]) + int'(m_tbl_b[ib])) >= 4;
endfunction

function automatic ctr_t train_counter(ctr_t c, logic taken);
  if (taken) begin
    return (c == 2'd3) ? c : c + 2'd1;
  end
  return (c == 2'd0) ? c : c - 2'd1;
endfunction

function automatic fetch_t expected_fetch();
  fetch_t f;
  f.ip = m_ip;
  f.pred_taken = model_dir_taken(m_ip, m_ghist) && model_btb_hit(m_ip);
  f.pred_target = m_btb_target[btb_slot(m_ip)];
  f.ghist = m_ghist;
  return f;
endfunction

task automatic model_reset();
  for (int i = 0; i < (1 << M_DIR_IDX_W); i++) begin
    m_tbl_a[i] = 2'd1;
    m_tbl_b[i] = 2'd1;
  end
  for (int i = 0; i < (1 << M_BTB_IDX_W); i++) begin
    m_btb_valid[i] = 1'b0;
  end
  m_ip = M_RESET_IP;
  m_ghist = '0;
  m_valid = 1'b0;
endtask

// one rising edge with the inputs seen at that edge
task automatic model_step(input logic ready, input retire_t r);
  fetch_t f;
  logic   hit;
  int     ia;
  int     ib;
  int     s;
  f = expected_fetch();
  hit = model_btb_hit(m_ip);
  if (r.valid && r.mispredict) begin
    m_ip = r.taken ? r.target : r.src_ip + addr_t'(BLOCK_BYTES);
    m_ghist = {r.ghist[HIST_W-2:0], r.taken};
  end else if (m_valid && ready) begin
    m_ip = f.pred_taken ? f.pred_target : m_ip + addr_t'(BLOCK_BYTES);
    if (hit) begin
      m_ghist = {m_ghist[HIST_W-2:0], f.pred_taken};
    end
  end
  m_valid = 1'b1;
  if (r.valid) begin
    ia = int'(r.src_ip[4 +: M_DIR_IDX_W]);
    ib = ia ^ int'(r.ghist[M_DIR_IDX_W-1:0]);
    m_tbl_a[ia] = train_counter(m_tbl_a[ia], r.taken);
    m_tbl_b[ib] = train_counter(m_tbl_b[ib], r.taken);
    if (r.taken) begin
      s = btb_slot(r.src_ip);
      m_btb_valid[s] = 1'b1;
      m_btb_src[s] = r.src_ip;
      m_btb_target[s] = r.target;
    end
  end
endtask

`endif

/* verification/fetch_frontend_tb.sv */
// fetch front end testbench comparing every cycle with the included reference model
// covers reset, sequential fetch, redirects, training and a random mix
`default_nettype none

module fetch_frontend_tb
  import fe_pred_pkg::*;
  import fe_addr_pkg::*;
;

  `include "fe_ref_model.svh"

  localparam int RESET_CYCLES = 2;
  localparam int SETUP_CYCLES = 16;  // valid wait, redirects, tail
  localparam int SEQ_CYCLES = 60;
  localparam int TRAIN_CYCLES = 24;
  localparam int RAND_CYCLES = 400;
  localparam int STIM_CYCLES = RESET_CYCLES + SETUP_CYCLES + SEQ_CYCLES + TRAIN_CYCLES
                               + RAND_CYCLES;
  localparam int TIMEOUT_CYCLES = STIM_CYCLES + 100;

  localparam addr_t  TRAIN_IP = 'h1450;
  localparam addr_t  TRAIN_TGT = 'h2800;
  localparam addr_t  REDIR_SRC = 'h7000;
  localparam ghist_t REDIR_GH = 16'h0012;
  localparam ghist_t TRAIN_GH = 16'h0025;  // REDIR_GH after a taken redirect
  localparam addr_t  RAND_BASE = 'h1000;

  logic    clk;
  logic    rst;
  logic    fetch_ready;
  retire_t retire;
  fetch_t  fetch;
  logic    fetch_valid;

  int   seed = 51;
  int   cycle_cnt = 0;
  int   stall_left = 0;
  logic model_live = 1'b0;

  fetch_frontend u_dut (
    .clk         (clk),
    .rst         (rst),
    .retire      (retire),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // ready low for random stretches of 1 to 8 cycles
  task automatic drive_ready_random();
    int r;
    r = $random(seed);
    if (stall_left == 0 && r[3:0] == 4'd0) begin
      stall_left = 1 + int'(r[6:4]);
    end
    if (stall_left > 0) begin
      stall_left--;
      fetch_ready <= 1'b0;
    end else begin
      fetch_ready <= 1'b1;
    end
  endtask

  // one retire update held for a single cycle
  task automatic send_retire(input addr_t src, input addr_t tgt, input logic taken,
                             input ghist_t gh, input logic mis);
    @(posedge clk);
    retire <= '{valid: 1'b1, src_ip: src, target: tgt, taken: taken, ghist: gh,
                mispredict: mis};
    @(posedge clk);
    retire <= '0;
  endtask

  // model follows every edge and counts cycles for the timeout
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end else if (rst) begin
      model_reset();
      model_live = 1'b1;
    end else if (model_live) begin
      model_step(fetch_ready, retire);
    end
  end

  always @(negedge clk) begin : compare_outputs
    fetch_t exp_f;
    if (model_live) begin
      exp_f = expected_fetch();
      check_value("fetch_valid", 64'(fetch_valid), 64'(m_valid));
      check_value("fetch.ip", 64'(fetch.ip), 64'(exp_f.ip));
      check_value("fetch.ghist", 64'(fetch.ghist), 64'(exp_f.ghist));
      check_value("fetch.pred_taken", 64'(fetch.pred_taken), 64'(exp_f.pred_taken));
      if (m_btb_valid[btb_slot(m_ip)]) begin  // unfilled entries hold no target
        check_value("fetch.pred_target", 64'(fetch.pred_target), 64'(exp_f.pred_target));
      end
    end
  end

  initial begin
    int r;
    rst = 1'b1;
    fetch_ready = 1'b0;
    retire = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    fetch_ready <= 1'b1;

    while (fetch_valid !== 1'b1) @(posedge clk);
    check_value("fetch.ip", 64'(fetch.ip), 64'(M_RESET_IP));
    check_value("fetch.pred_taken", 64'(fetch.pred_taken), 64'd0);
    check_value("fetch.ghist", 64'(fetch.ghist), 64'd0);

    repeat (SEQ_CYCLES) begin
      @(posedge clk);
      drive_ready_random();
    end

    // redirects while stalled
    fetch_ready <= 1'b0;
    send_retire('h2000, 'h5000, 1'b1, 16'h00a5, 1'b1);
    @(posedge clk);
    check_value("fetch.ip", 64'(fetch.ip), 64'h5000);
    check_value("fetch.ghist", 64'(fetch.ghist), 64'h014b);
    send_retire('h3000, 'h6000, 1'b0, 16'h0003, 1'b1);
    @(posedge clk);
    check_value("fetch.ip", 64'(fetch.ip), 64'h3010);
    check_value("fetch.ghist", 64'(fetch.ghist), 64'h0006);

    // train one block to strongly taken, then fetch it
    repeat (3) send_retire(TRAIN_IP, TRAIN_TGT, 1'b1, TRAIN_GH, 1'b0);
    send_retire(REDIR_SRC, TRAIN_IP, 1'b1, REDIR_GH, 1'b1);
    @(posedge clk);
    check_value("fetch.ip", 64'(fetch.ip), 64'(TRAIN_IP));
    check_value("fetch.pred_taken", 64'(fetch.pred_taken), 64'd1);
    check_value("fetch.pred_target", 64'(fetch.pred_target), 64'(TRAIN_TGT));
    fetch_ready <= 1'b1;
    @(posedge clk);
    fetch_ready <= 1'b0;
    @(posedge clk);
    check_value("fetch.ip", 64'(fetch.ip), 64'(TRAIN_TGT));
    check_value("fetch.ghist", 64'(fetch.ghist), 64'({TRAIN_GH[HIST_W-2:0], 1'b1}));

    // untrain back to not taken
    repeat (3) send_retire(TRAIN_IP, TRAIN_TGT, 1'b0, TRAIN_GH, 1'b0);
    send_retire(REDIR_SRC, TRAIN_IP, 1'b1, REDIR_GH, 1'b1);
    @(posedge clk);
    check_value("fetch.pred_taken", 64'(fetch.pred_taken), 64'd0);

    // random mix over a few blocks near RAND_BASE
    repeat (RAND_CYCLES) begin
      @(posedge clk);
      drive_ready_random();
      r = $random(seed);
      if (r[1:0] == 2'd0) begin
        retire <= '{valid: 1'b1,
                    src_ip: RAND_BASE + addr_t'({r[4:2], 4'h0}),
                    target: RAND_BASE + addr_t'({r[7:5], 4'h0}),
                    taken: r[8],
                    ghist: fetch.ghist,
                    mispredict: (r[11:9] == 3'd0)};
      end else begin
        retire <= '0;
      end
    end

    @(posedge clk);
    retire <= '0;
    fetch_ready <= 1'b1;
    repeat (4) @(posedge clk);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/direction_predictor.sv */
// taken/not-taken prediction from two 2-bit counter tables
// table A by block address, table B by address xor global history
`default_nettype none

module direction_predictor
  import fe_pred_pkg::*;
  import fe_addr_pkg::*;
#(
  parameter int DIR_IDX_W = 8
) (
  input  wire            clk,
  input  wire            rst,
  input  wire addr_t     cur_ip,
  input  wire ghist_t    cur_ghist,
  input  wire retire_t   retire,
  output dir_pred_t      dir
);

  localparam int DIR_ENTRIES = 1 << DIR_IDX_W;

  typedef logic [DIR_IDX_W-1:0] dir_idx_t;

  ctr_t [DIR_ENTRIES-1:0] tbl_a;  // address only
  ctr_t [DIR_ENTRIES-1:0] tbl_b;  // address mixed with history

  dir_idx_t rd_idx_a;
  dir_idx_t rd_idx_b;
  dir_idx_t wr_idx_a;
  dir_idx_t wr_idx_b;
  ctr_t     rd_a;
  ctr_t     rd_b;
  ctr_t     wr_a_old;
  ctr_t     wr_b_old;
  logic [2:0] ctr_sum;

  // one step toward the outcome, held at both ends
  function automatic ctr_t ctr_step(ctr_t c, logic up);
    ctr_t n;
    n = c;
    if (up && c != CTR_MAX) begin
      n = c + 2'd1;
    end else if (!up && c != CTR_MIN) begin
      n = c - 2'd1;
    end
    return n;
  endfunction

  // lookup for the block being fetched
  assign rd_idx_a = cur_ip[BLOCK_OFF_W +: DIR_IDX_W];
  assign rd_idx_b = rd_idx_a ^ cur_ghist[DIR_IDX_W-1:0];
  assign rd_a = tbl_a[rd_idx_a];
  assign rd_b = tbl_b[rd_idx_b];

  assign ctr_sum = {1'b0, rd_a} + {1'b0, rd_b};
  assign dir = '{taken: (ctr_sum >= 3'd4)};  // both weak taken or one strong

  // training side, same index pair as at fetch of the retired block
  assign wr_idx_a = retire.src_ip[BLOCK_OFF_W +: DIR_IDX_W];
  assign wr_idx_b = wr_idx_a ^ retire.ghist[DIR_IDX_W-1:0];
  assign wr_a_old = tbl_a[wr_idx_a];
  assign wr_b_old = tbl_b[wr_idx_b];

  always_ff @(posedge clk) begin
    if (rst) begin
      tbl_a <= {DIR_ENTRIES{CTR_INIT}};
      tbl_b <= {DIR_ENTRIES{CTR_INIT}};
    end else if (retire.valid) begin
      tbl_a[wr_idx_a] <= ctr_step(wr_a_old, retire.taken);
      tbl_b[wr_idx_b] <= ctr_step(wr_b_old, retire.taken);
    end
  end

  // trained counters never wrap past 3 or below 0
  a_ctr_up: assert property (@(posedge clk) disable iff (rst)
    retire.valid && retire.taken |=>
      tbl_a[$past(wr_idx_a)] >= $past(wr_a_old) &&
      tbl_b[$past(wr_idx_b)] >= $past(wr_b_old))
    else $error("taken retire wrapped a direction counter");

  a_ctr_down: assert property (@(posedge clk) disable iff (rst)
    retire.valid && !retire.taken |=>
      tbl_a[$past(wr_idx_a)] <= $past(wr_a_old) &&
      tbl_b[$past(wr_idx_b)] <= $past(wr_b_old))
    else $error("not-taken retire wrapped a direction counter");

endmodule

`default_nettype wire

/* verilog/fe_addr_pkg.sv */
// fetch address, offered fetch block and retired branch update
// shared by the front end RTL and its testbench
`default_nettype none

package fe_addr_pkg;

  import fe_pred_pkg::*;

  localparam int ADDR_W = TARGET_W;  // byte address width
  localparam int BLOCK_BYTES = 16;
  localparam int BLOCK_OFF_W = $clog2(BLOCK_BYTES);  // low bits, always zero

  typedef logic [ADDR_W-1:0] addr_t;

  // one fetch block as offered to the decoder
  typedef struct packed {
    addr_t  ip;
    logic   pred_taken;
    addr_t  pred_target;
    ghist_t ghist;        // history the prediction was made with
  } fetch_t;

  // one retired branch from the back end
  typedef struct packed {
    logic   valid;
    addr_t  src_ip;       // block holding the branch
    addr_t  target;
    logic   taken;
    ghist_t ghist;        // history at fetch of that block
    logic   mispredict;
  } retire_t;

endpackage

`default_nettype wire

/* verilog/fe_pred_pkg.sv */
// predictor-side types: saturating counters, global history and the lookup results
// compiled first, fe_addr_pkg takes its history type from here
`default_nettype none

package fe_pred_pkg;

  localparam int HIST_W = 16;    // global history length
  localparam int TARGET_W = 48;  // predicted target, a full fetch address

  // newest branch outcome sits in bit 0
  typedef logic [HIST_W-1:0] ghist_t;

  // 2-bit saturating counter, 0..1 not taken, 2..3 taken
  typedef logic [1:0] ctr_t;

  localparam ctr_t CTR_INIT = 2'd1;  // weakly not taken
  localparam ctr_t CTR_MIN = 2'd0;
  localparam ctr_t CTR_MAX = 2'd3;

  // combined answer of the two counter tables
  typedef struct packed {
    logic taken;
  } dir_pred_t;

  // target buffer lookup for the current block
  typedef struct packed {
    logic                hit;
    logic [TARGET_W-1:0] target;
  } btb_pred_t;

endpackage

`default_nettype wire

/* verilog/fetch_frontend.sv */
// instruction fetch front end top, direction predictor and target buffer
// feeding the next-address selector
`default_nettype none

module fetch_frontend
  import fe_pred_pkg::*;
  import fe_addr_pkg::*;
#(
  parameter int    DIR_IDX_W = 8,
  parameter int    BTB_IDX_W = 6,
  parameter addr_t RESET_IP = 'h1000
) (
  input  wire          clk,
  input  wire          rst,
  input  wire retire_t retire,
  output wire fetch_t  fetch,
  output wire          fetch_valid,
  input  wire          fetch_ready
);

  wire addr_t     cur_ip;
  wire ghist_t    cur_ghist;
  wire dir_pred_t dir;
  wire btb_pred_t btb;

  direction_predictor #(
    .DIR_IDX_W (DIR_IDX_W)
  ) u_dir (
    .clk       (clk),
    .rst       (rst),
    .cur_ip    (cur_ip),
    .cur_ghist (cur_ghist),
    .retire    (retire),
    .dir       (dir)
  );

  target_buffer #(
    .BTB_IDX_W (BTB_IDX_W)
  ) u_btb (
    .clk    (clk),
    .rst    (rst),
    .cur_ip (cur_ip),
    .retire (retire),
    .btb    (btb)
  );

  next_ip_select #(
    .RESET_IP (RESET_IP)
  ) u_nip (
    .clk         (clk),
    .rst         (rst),
    .dir         (dir),
    .btb         (btb),
    .retire      (retire),
    .cur_ip      (cur_ip),
    .cur_ghist   (cur_ghist),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready)
  );

endmodule

`default_nettype wire

/* verilog/next_ip_select.sv */
// fetch address and global history registers, next-block choice and retire redirect
// offers one block per cycle under a valid/ready handshake
`default_nettype none

module next_ip_select
  import fe_pred_pkg::*;
  import fe_addr_pkg::*;
#(
  parameter addr_t RESET_IP = 'h1000
) (
  input  wire            clk,
  input  wire            rst,
  input  wire dir_pred_t dir,
  input  wire btb_pred_t btb,
  input  wire retire_t   retire,
  output addr_t          cur_ip,
  output ghist_t         cur_ghist,
  output fetch_t         fetch,
  output logic           fetch_valid,
  input  wire            fetch_ready
);

  addr_t  ip_q;
  ghist_t ghist_q;
  logic   valid_q;

  logic   pred_taken;
  logic   xfer;
  logic   redirect;
  addr_t  seq_ip;
  addr_t  redirect_ip;

  // a taken prediction needs a target to go to
  assign pred_taken = dir.taken && btb.hit;
  assign seq_ip = ip_q + addr_t'(BLOCK_BYTES);

  assign xfer = fetch_valid && fetch_ready;
  assign redirect = retire.valid && retire.mispredict;
  assign redirect_ip = retire.taken ? retire.target
                                    : retire.src_ip + addr_t'(BLOCK_BYTES);

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q    <= RESET_IP;
      ghist_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;  // one idle cycle after reset
      if (redirect) begin
        // wins over a transfer, offered block is dropped
        ip_q    <= redirect_ip;
        ghist_q <= {retire.ghist[HIST_W-2:0], retire.taken};
      end else if (xfer) begin
        ip_q <= pred_taken ? addr_t'(btb.target) : seq_ip;
        if (btb.hit) begin
          ghist_q <= {ghist_q[HIST_W-2:0], pred_taken};
        end
      end
    end
  end

  assign cur_ip = ip_q;
  assign cur_ghist = ghist_q;
  assign fetch_valid = valid_q;

  assign fetch = '{
    ip:          ip_q,
    pred_taken:  pred_taken,
    pred_target: addr_t'(btb.target),
    ghist:       ghist_q
  };

  // stalled block holds, prediction may only move if the tables were trained
  a_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_valid && !fetch_ready && !redirect |=>
      fetch_valid && $stable(fetch.ip) && $stable(fetch.ghist) &&
      ($past(retire.valid) || $stable(fetch)))
    else $error("fetch block changed while stalled");

endmodule

`default_nettype wire

/* verilog/target_buffer.sv */
// direct-mapped branch target buffer, looked up with the current fetch block
// filled at retire by every taken branch
`default_nettype none

module target_buffer
  import fe_pred_pkg::*;
  import fe_addr_pkg::*;
#(
  parameter int BTB_IDX_W = 6
) (
  input  wire            clk,
  input  wire            rst,
  input  wire addr_t     cur_ip,
  input  wire retire_t   retire,
  output btb_pred_t      btb
);

  localparam int BTB_ENTRIES = 1 << BTB_IDX_W;
  localparam int TAG_LSB = BLOCK_OFF_W + BTB_IDX_W;
  localparam int TAG_W = ADDR_W - TAG_LSB;  // everything above the index

  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [TAG_W-1:0]     btb_tag_t;

  typedef struct packed {
    btb_tag_t tag;
    addr_t    target;
  } btb_entry_t;

  logic [BTB_ENTRIES-1:0] ent_valid;
  btb_entry_t             ent_mem [BTB_ENTRIES];

  btb_idx_t   rd_idx;
  btb_tag_t   rd_tag;
  btb_entry_t rd_ent;
  btb_idx_t   wr_idx;
  logic       fill;

  // lookup
  assign rd_idx = cur_ip[BLOCK_OFF_W +: BTB_IDX_W];
  assign rd_tag = cur_ip[TAG_LSB +: TAG_W];
  assign rd_ent = ent_mem[rd_idx];

  assign btb = '{
    hit:    ent_valid[rd_idx] && (rd_ent.tag == rd_tag),
    target: rd_ent.target
  };

  // only a taken retire fills its entry
  assign fill = retire.valid && retire.taken;
  assign wr_idx = retire.src_ip[BLOCK_OFF_W +: BTB_IDX_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid <= '0;
    end else if (fill) begin
      ent_valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      ent_mem[wr_idx] <= '{
        tag:    retire.src_ip[TAG_LSB +: TAG_W],
        target: retire.target
      };
    end
  end

  // back end must only hand over block-aligned targets
  a_fill_aligned: assert property (@(posedge clk) disable iff (rst)
    fill |=> ent_mem[$past(wr_idx)].target[BLOCK_OFF_W-1:0] == '0)
    else $error("target buffer filled with an unaligned target");

endmodule

`default_nettype wire
